// ==== Makefile ====
# Verilator simulation of the front end, every variable can be overridden
VERILATOR ?= verilator
TOP ?= coreFrontEnd_tb
FILELIST ?= coreFrontEnd.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Done: errors found
PASS_MSG ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== coreFrontEnd.f ====
+incdir+include
src/corePkg.sv
src/fetchUnit.sv
src/decodeBuffer.sv
src/regScoreboard.sv
src/regFile.sv
src/coreFrontEnd.sv
sim/coreFrontEnd_tb.sv

// ==== include/core_consts.svh ====
/*
 * Fixed sizes of the fetch front end: decode buffer, bus line and beat,
 * instruction window and register file. Include wherever one of these
 * sizes is needed; types built on them live in the core package.
 */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// decode buffer and bus geometry
`define BUF_BYTES 128 // circular decode buffer, power of two
`define LINE_BYTES 64 // one bus request brings a full line
`define WORD_BYTES 8 // bytes carried by each response beat

// longest x86 instruction, also the width of the decoder window
`define WINDOW_BYTES 15

// request a new line once fewer bytes than this await decoding
`define REFILL_LEVEL 32

`define NUM_REGS 16 // architectural integer registers

`endif

// ==== sim/coreFrontEnd_tb.sv ====
/*
 * Testbench for the front end. A memory model serves line requests, a
 * decoder model consumes bytes and offers register codes, an execute
 * model retires issued instructions. Reference models of the fill level,
 * the in-use map and the registers feed the concurrent assertions.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module coreFrontEnd_tb;
   import corePkg::*;

   localparam addrT entryAddr = 64'h1028;
   localparam addrT firstLine = 64'h1000; // line holding the entry
   localparam int targetBytes = 1000; // decoded bytes before the run ends
   localparam int cycleLimit = 4 * targetBytes; // worst case near four cycles a byte

   logic bus = 1'b0;
   logic arstN, reqCyc, reqAck, respCyc, respAck, canDecode, stall;
   logic src1Valid, src2Valid, destSpecialValid;
   logic wbValid, wbSrc1Valid, wbSrc2Valid, wbDestSpecialValid;
   addrT entry, reqAddr;
   logic [11:0] reqTag;
   wordT respData, wbResult, wbResultSpecial, rdData1, rdData2;
   windowT window;
   byteCountT bytesConsumed;
   regCodeT src1, src2, dest, destSpecial, wbSrc1, wbSrc2, wbDest, wbDestSpecial;
   regCodeT rdAddr1, rdAddr2;

   // instruction record {v1, v2, vs, s1, s2, d, ds}
   logic [18:0] offered, retired;
   logic [18:0] pending [$]; // issued, waiting for execute
   logic [`NUM_REGS-1:0] modelInUse;
   logic [`NUM_REGS-1:0][63:0] modelRegs;
   int deliveredBytes, consumedBytes, ackCount;
   int errorCount = 0;
   int cycleCount = 0;
   addrT beatAddr; // address of the beat on respData
   logic lineBusy; // a line is acknowledged and not yet fully sent

   assign offered = {src1Valid, src2Valid, destSpecialValid, src1, src2, dest, destSpecial};
   assign retired = {wbSrc1Valid, wbSrc2Valid, wbDestSpecialValid,
      wbSrc1, wbSrc2, wbDest, wbDestSpecial};

   coreFrontEnd dut0 (.*);

   initial begin
      forever #4 bus = ~bus;
   end

   function automatic logic [7:0] memByte(addrT a);
      return a[7:0] ^ 8'h5a;
   endfunction

   function automatic windowT expectedWindow(int offset);
      windowT w;
      for (int k = 0; k < `WINDOW_BYTES; k++) begin
         w[(`WINDOW_BYTES - 1 - k)*8 +: 8] = memByte(entryAddr + addrT'(offset + k));
      end
      return w;
   endfunction

   // registers named by an instruction, destination always counts
   function automatic logic [`NUM_REGS-1:0] regMask(logic [18:0] ins);
      logic [`NUM_REGS-1:0] m;
      m = '0;
      m[ins[7:4]] = 1'b1;
      if (ins[18]) m[ins[15:12]] = 1'b1;
      if (ins[17]) m[ins[11:8]] = 1'b1;
      if (ins[16]) m[ins[3:0]] = 1'b1;
      return m;
   endfunction

   task automatic logMismatch(string msg);
      errorCount++;
      $display("mismatch at %0t ns: %s", $time, msg);
   endtask

   task automatic logProblem(string msg);
      errorCount++;
      $display("%s", msg);
   endtask

   task automatic finishRun();
      $display("errors %0d, cycles %0d, bytes decoded %0d", errorCount, cycleCount,
         consumedBytes);
      if (errorCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // read back what was just retired, otherwise any register
   task automatic pointReadPorts();
      if (wbValid) begin
         rdAddr1 = wbDest;
         rdAddr2 = wbDestSpecialValid ? wbDestSpecial : wbDest;
      end else begin
         {rdAddr1, rdAddr2} = 8'($urandom);
      end
   endtask

   // reference models follow the DUT inputs at each edge
   always @(posedge bus or negedge arstN) begin
      if (!arstN) begin
         modelInUse <= '0;
         modelRegs <= '0;
         deliveredBytes <= 0;
         consumedBytes <= 0;
         ackCount <= 0;
      end else begin
         if (respCyc && beatAddr >= entryAddr) deliveredBytes <= deliveredBytes + `WORD_BYTES;
         consumedBytes <= consumedBytes + int'(bytesConsumed);
         if (reqAck) ackCount <= ackCount + 1;
         modelInUse <= (modelInUse & ~(wbValid ? regMask(retired) : '0))
            | ((bytesConsumed != '0) ? regMask(offered) : '0);
         if (wbValid) begin
            modelRegs[wbDest] <= wbResult;
            if (wbDestSpecialValid) modelRegs[wbDestSpecial] <= wbResultSpecial; // special wins
         end
      end
   end

   always @(posedge bus) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         logProblem($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
         finishRun();
      end
   end

   // memory: ack, a gap of 1 to 4 cycles, then eight beats of the line
   initial begin : memoryModel
      addrT lineAddr;
      int gap;
      reqAck = 1'b0;
      respCyc = 1'b0;
      respData = '0;
      beatAddr = '0;
      lineBusy = 1'b0;
      forever begin
         @(negedge bus);
         if (arstN && reqCyc) begin
            lineAddr = reqAddr;
            gap = $urandom_range(4, 1);
            reqAck = 1'b1;
            @(negedge bus);
            reqAck = 1'b0;
            lineBusy = 1'b1;
            repeat (gap - 1) @(negedge bus);
            for (int b = 0; b < 8; b++) begin
               beatAddr = lineAddr + addrT'(8 * b);
               for (int i = 0; i < 8; i++) begin
                  respData[(7 - i)*8 +: 8] = memByte(beatAddr + addrT'(i)); // byte 0 on top
               end
               respCyc = 1'b1;
               @(negedge bus);
            end
            respCyc = 1'b0;
            lineBusy = 1'b0;
         end
      end
   end

   // decoder and execute stimulus
   initial begin : stimulus
      logic [18:0] ins;
      logic [18:0] newIns; // instruction offered this cycle
      int retireWait;
      int want;
      void'($urandom(32'hbdc6));
      arstN = 1'b0;
      entry = entryAddr;
      bytesConsumed = '0;
      {src1, src2, dest, destSpecial, src1Valid, src2Valid, destSpecialValid} = '0;
      {wbValid, wbSrc1Valid, wbSrc2Valid, wbDestSpecialValid} = '0;
      {wbSrc1, wbSrc2, wbDest, wbDestSpecial, rdAddr1, rdAddr2} = '0;
      wbResult = '0;
      wbResultSpecial = '0;
      retireWait = 0;
      repeat (4) @(negedge bus);
      arstN = 1'b1;
      while (consumedBytes < targetBytes || pending.size() != 0) begin
         @(negedge bus);
         pointReadPorts();
         wbValid = 1'b0;
         if (retireWait > 0) begin
            retireWait--;
         end else if (pending.size() != 0) begin
            ins = pending.pop_front();
            {wbSrc1Valid, wbSrc2Valid, wbDestSpecialValid} = ins[18:16];
            {wbSrc1, wbSrc2, wbDest, wbDestSpecial} = ins[15:0];
            wbResult = {$urandom, $urandom};
            wbResultSpecial = {$urandom, $urandom};
            wbValid = 1'b1;
            retireWait = $urandom_range(3, 0);
         end
         {src1, src2, dest, destSpecial} = 16'($urandom);
         {src1Valid, src2Valid, destSpecialValid} = 3'($urandom);
         newIns = {src1Valid, src2Valid, destSpecialValid, src1, src2, dest, destSpecial};
         want = $urandom_range(15, 0);
         if (want > deliveredBytes - consumedBytes) want = deliveredBytes - consumedBytes;
         if (consumedBytes >= targetBytes || deliveredBytes - consumedBytes < `WINDOW_BYTES
            || (modelInUse & regMask(newIns)) != '0) begin
            want = 0; // no window yet or a hazard
         end
         bytesConsumed = byteCountT'(want);
         if (want != 0) pending.push_back(newIns);
      end
      @(negedge bus);
      pointReadPorts();
      wbValid = 1'b0;
      bytesConsumed = '0;
      repeat (3) @(negedge bus);
      finishRun();
   end

   resetState: assert property (@(posedge bus) $rose(arstN) |->
         !reqCyc && !canDecode && !stall && rdData1 == '0 && rdData2 == '0)
      else logMismatch("outputs differ from their reset values");

   respAckFollows: assert property (@(posedge bus) respAck == respCyc)
      else logMismatch($sformatf("respAck %b, respCyc %b", $sampled(respAck),
         $sampled(respCyc)));

   // the read tag is a fixed code for every request
   tagFixed: assert property (@(posedge bus) disable iff (!arstN)
         !$isunknown(reqTag) && $stable(reqTag))
      else logMismatch($sformatf("reqTag %h changed or unknown", $sampled(reqTag)));

   lineStep: assert property (@(posedge bus) disable iff (!arstN)
         $rose(reqCyc) |-> reqAddr == firstLine + 64'(ackCount * `LINE_BYTES))
      else logMismatch($sformatf("reqAddr %h, expected %h", $sampled(reqAddr),
         firstLine + 64'($sampled(ackCount) * `LINE_BYTES)));

   oneLineInFlight: assert property (@(posedge bus) disable iff (!arstN)
         $rose(reqCyc) |-> !lineBusy)
      else logProblem("reqCyc rose while a line was still outstanding");

   decodeReady: assert property (@(posedge bus) disable iff (!arstN)
         canDecode == (deliveredBytes - consumedBytes >= `WINDOW_BYTES))
      else logMismatch($sformatf("canDecode %b with %0d bytes buffered",
         $sampled(canDecode), $sampled(deliveredBytes - consumedBytes)));

   windowBytes: assert property (@(posedge bus) disable iff (!arstN)
         canDecode |-> window == expectedWindow(consumedBytes))
      else logMismatch($sformatf("window %h, expected %h", $sampled(window),
         expectedWindow($sampled(consumedBytes))));

   stallRule: assert property (@(posedge bus) disable iff (!arstN)
         stall == ((modelInUse & regMask(offered)) != '0))
      else logMismatch($sformatf("stall %b, in-use map %h", $sampled(stall),
         $sampled(modelInUse)));

   readPorts: assert property (@(posedge bus) disable iff (!arstN)
         rdData1 == modelRegs[rdAddr1] && rdData2 == modelRegs[rdAddr2])
      else logMismatch($sformatf("r%0d read %h expected %h, r%0d read %h expected %h",
         $sampled(rdAddr1), $sampled(rdData1), $sampled(modelRegs[rdAddr1]),
         $sampled(rdAddr2), $sampled(rdData2), $sampled(modelRegs[rdAddr2])));

endmodule

`default_nettype wire

// ==== src/coreFrontEnd.sv ====
/*
 * Front end of the pipeline. Connects fetch, decode buffer, scoreboard
 * and register file to the memory bus, the external decoder and the
 * external execute stage. An issue is any cycle in which the decoder
 * consumes bytes.
 */
`timescale 1ns/1ps
`default_nettype none

module coreFrontEnd (
   input wire logic bus,
   input wire logic arstN,
   input wire corePkg::addrT entry,
   // memory bus
   output logic reqCyc,
   output corePkg::addrT reqAddr,
   output logic [11:0] reqTag,
   input wire logic reqAck,
   input wire logic respCyc,
   input wire corePkg::wordT respData,
   output logic respAck,
   // decoder side
   output corePkg::windowT window,
   output logic canDecode,
   input wire corePkg::byteCountT bytesConsumed,
   input wire corePkg::regCodeT src1,
   input wire corePkg::regCodeT src2,
   input wire corePkg::regCodeT dest,
   input wire corePkg::regCodeT destSpecial,
   input wire logic src1Valid,
   input wire logic src2Valid,
   input wire logic destSpecialValid,
   output logic stall,
   // execute side
   input wire logic wbValid,
   input wire corePkg::regCodeT wbSrc1,
   input wire corePkg::regCodeT wbSrc2,
   input wire corePkg::regCodeT wbDest,
   input wire corePkg::regCodeT wbDestSpecial,
   input wire logic wbSrc1Valid,
   input wire logic wbSrc2Valid,
   input wire logic wbDestSpecialValid,
   input wire corePkg::wordT wbResult,
   input wire corePkg::wordT wbResultSpecial,
   input wire corePkg::regCodeT rdAddr1,
   input wire corePkg::regCodeT rdAddr2,
   output corePkg::wordT rdData1,
   output corePkg::wordT rdData2
);
   import corePkg::*;

   logic fillValid;
   wordT fillData;
   logic roomForLine;
   logic issue;

   assign respAck = respCyc; // responses are always accepted
   assign issue = (bytesConsumed != '0);

   fetchUnit fetch0 (
      .bus, .arstN, .entry, .reqAck, .respCyc, .respData, .roomForLine,
      .reqCyc, .reqAddr, .reqTag, .fillValid, .fillData
   );

   decodeBuffer dbuf0 (
      .bus, .arstN, .fillValid, .fillData, .bytesConsumed,
      .window, .canDecode, .roomForLine
   );

   regScoreboard sb0 (
      .bus, .arstN, .issue, .src1, .src2, .dest, .destSpecial,
      .src1Valid, .src2Valid, .destSpecialValid,
      .wbValid, .wbSrc1, .wbSrc2, .wbDest, .wbDestSpecial,
      .wbSrc1Valid, .wbSrc2Valid, .wbDestSpecialValid, .stall
   );

   regFile rf0 (
      .bus, .arstN, .wbValid, .wbDest, .wbDestSpecial, .rdAddr1, .rdAddr2,
      .wbDestSpecialValid, .wbResult, .wbResultSpecial, .rdData1, .rdData2
   );

endmodule

`default_nettype wire

// ==== src/corePkg.sv ====
/*
 * Shared types of the front end. Modules import this package inside
 * their bodies and use scoped names in their port lists.
 */
`default_nettype none

`include "core_consts.svh"

package corePkg;

   typedef logic [63:0] addrT; // byte address
   typedef logic [63:0] wordT; // bus beat and register value
   typedef logic [3:0] regCodeT; // register number

   // offset into the decode buffer, wraps with the buffer size
   typedef logic [$clog2(`BUF_BYTES)-1:0] bufOffsetT;

   typedef logic [3:0] byteCountT; // bytes consumed per cycle, 0 to 15

   typedef logic [`WINDOW_BYTES*8-1:0] windowT; // byte 0 in the top byte

   typedef enum logic [1:0] {
      fetchIdle, // no line outstanding
      fetchWaiting, // acknowledged, no data yet
      fetchActive // beats arriving
   } fetchStateT;

endpackage

`default_nettype wire

// ==== src/decodeBuffer.sv ====
/*
 * Circular byte buffer between fetch and the decoder. Fetch writes one
 * beat at a time at the fill offset; the decoder sees a 15-byte window
 * at the decode offset and reports how many bytes it used each cycle.
 * Beat byte 0 sits in the top byte of the beat, as in the window.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module decodeBuffer (
   input wire logic bus,
   input wire logic arstN,
   input wire logic fillValid,
   input wire corePkg::wordT fillData,
   input wire corePkg::byteCountT bytesConsumed,
   output corePkg::windowT window,
   output logic canDecode,
   output logic roomForLine
);
   import corePkg::*;

   logic [7:0] bufMem [0:`BUF_BYTES-1];

   bufOffsetT fillOffset;
   bufOffsetT decodeOffset;
   bufOffsetT fillLevel; // bytes waiting for the decoder

   assign fillLevel = fillOffset - decodeOffset; // wraps with the buffer

   assign canDecode = fillLevel >= bufOffsetT'(`WINDOW_BYTES);
   assign roomForLine = fillLevel < bufOffsetT'(`REFILL_LEVEL);

   // window bytes, index wraps past the end of the buffer
   for (genvar k = 0; k < `WINDOW_BYTES; k++) begin : gWin
      bufOffsetT idx;
      assign idx = decodeOffset + bufOffsetT'(k);
      assign window[(`WINDOW_BYTES - 1 - k)*8 +: 8] = bufMem[idx];
   end

   always_ff @(posedge bus) begin
      if (fillValid) begin
         for (int i = 0; i < `WORD_BYTES; i++) begin
            bufMem[fillOffset + bufOffsetT'(i)] <= fillData[(`WORD_BYTES - 1 - i)*8 +: 8];
         end
      end
   end

   always_ff @(posedge bus or negedge arstN) begin
      if (!arstN) begin
         fillOffset <= '0;
         decodeOffset <= '0;
      end else begin
         if (fillValid) begin
            fillOffset <= fillOffset + bufOffsetT'(`WORD_BYTES);
         end
         decodeOffset <= decodeOffset + {3'b000, bytesConsumed};
      end
   end

   // the decoder only eats bytes that fetch has delivered
   consumeBeyondFill: assert property (
      @(posedge bus) disable iff (!arstN)
      {3'b000, bytesConsumed} <= fillLevel
   );

   // and only once a full window is present
   consumeWithoutWindow: assert property (
      @(posedge bus) disable iff (!arstN)
      (bytesConsumed != '0) |-> canDecode
   );

   // the refill threshold keeps a full line from overrunning unread bytes
   noOverrun: assert property (
      @(posedge bus) disable iff (!arstN)
      fillValid |-> fillLevel <= bufOffsetT'(`BUF_BYTES - `WORD_BYTES)
   );

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
/*
 * Instruction fetch over the memory bus. Requests one line at a time
 * while the decode buffer has room, steps the line address and hands
 * each useful beat to the decode buffer. Beats in front of the entry
 * address in the first line are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module fetchUnit (
   input wire logic bus,
   input wire logic arstN,
   input wire corePkg::addrT entry,
   input wire logic reqAck,
   input wire logic respCyc,
   input wire corePkg::wordT respData,
   input wire logic roomForLine,
   output logic reqCyc,
   output corePkg::addrT reqAddr,
   output logic [11:0] reqTag,
   output logic fillValid,
   output corePkg::wordT fillData
);
   import corePkg::*;

   // read request to memory space: read bit, memory space, no extra bits
   localparam logic [11:0] readMemTag = {1'b1, 3'b001, 8'h00};

   localparam addrT lineMask = ~addrT'(`LINE_BYTES - 1);

   fetchStateT state;
   addrT fetchAddr; // address of the next beat to arrive
   logic [5:0] skipCount; // bytes still to drop from the first line
   logic sendReq;

   // only one line in flight; an ack this cycle means one was just taken
   assign sendReq = (state == fetchIdle) && !reqAck && roomForLine;

   assign reqTag = readMemTag;

   assign fillValid = respCyc && (skipCount == '0);
   assign fillData = respData; // beat goes straight into the buffer

   always_ff @(posedge bus or negedge arstN) begin
      if (!arstN) begin
         state <= fetchIdle;
         fetchAddr <= entry & lineMask; // start at the line holding the entry
         skipCount <= entry[5:0];
         reqCyc <= 1'b0;
         reqAddr <= '0;
      end else begin
         reqCyc <= sendReq;
         reqAddr <= fetchAddr & lineMask;

         if (respCyc) begin
            state <= fetchActive;
            fetchAddr <= fetchAddr + addrT'(`WORD_BYTES);
            if (skipCount != '0) begin
               skipCount <= skipCount - 6'(`WORD_BYTES); // beat lies before the entry
            end
         end else if (state == fetchActive) begin
            state <= fetchIdle; // burst over
         end else if (reqAck) begin
            state <= fetchWaiting;
         end
      end
   end

   // memory must not answer unless a request is outstanding
   respWithoutRequest: assert property (
      @(posedge bus) disable iff (!arstN)
      respCyc |-> !sendReq
   );

   // the memory acknowledges a request only while nothing else is in flight
   ackOutsideIdle: assert property (
      @(posedge bus) disable iff (!arstN)
      reqAck |-> (state == fetchIdle)
   );

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
/*
 * Architectural register file. Two combinational read ports and a dual
 * write from the execute stage on retire; the special result wins when
 * both writes target the same register.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module regFile (
   input wire logic bus,
   input wire logic arstN,
   input wire logic wbValid,
   input wire corePkg::regCodeT wbDest,
   input wire corePkg::regCodeT wbDestSpecial,
   input wire corePkg::regCodeT rdAddr1,
   input wire corePkg::regCodeT rdAddr2,
   input wire logic wbDestSpecialValid,
   input wire corePkg::wordT wbResult,
   input wire corePkg::wordT wbResultSpecial,
   output corePkg::wordT rdData1,
   output corePkg::wordT rdData2
);
   import corePkg::*;

   wordT regs [0:`NUM_REGS-1];

   assign rdData1 = regs[rdAddr1];
   assign rdData2 = regs[rdAddr2];

   always_ff @(posedge bus or negedge arstN) begin
      if (!arstN) begin
         for (int r = 0; r < `NUM_REGS; r++) begin
            regs[r] <= '0; // registers start out zero
         end
      end else if (wbValid) begin
         regs[wbDest] <= wbResult;
         if (wbDestSpecialValid) begin
            regs[wbDestSpecial] <= wbResultSpecial; // last write wins on a clash
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/regScoreboard.sv ====
/*
 * Register scoreboard. One in-use bit per register: an issued
 * instruction marks its sources and destinations, its retire clears
 * them again. stall goes high when the instruction offered by the
 * decoder touches a register that is still in use.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module regScoreboard (
   input wire logic bus,
   input wire logic arstN,
   input wire logic issue,
   input wire corePkg::regCodeT src1,
   input wire corePkg::regCodeT src2,
   input wire corePkg::regCodeT dest,
   input wire corePkg::regCodeT destSpecial,
   input wire logic src1Valid,
   input wire logic src2Valid,
   input wire logic destSpecialValid,
   input wire logic wbValid,
   input wire corePkg::regCodeT wbSrc1,
   input wire corePkg::regCodeT wbSrc2,
   input wire corePkg::regCodeT wbDest,
   input wire corePkg::regCodeT wbDestSpecial,
   input wire logic wbSrc1Valid,
   input wire logic wbSrc2Valid,
   input wire logic wbDestSpecialValid,
   output logic stall
);
   import corePkg::*;

   logic [`NUM_REGS-1:0] inUse;
   logic [`NUM_REGS-1:0] setMask; // registers taken by this issue
   logic [`NUM_REGS-1:0] clrMask; // registers freed by this retire

   // the destination is always checked, the others only when valid
   assign stall = (src1Valid && inUse[src1]) || (src2Valid && inUse[src2])
      || inUse[dest] || (destSpecialValid && inUse[destSpecial]);

   always_comb begin
      setMask = '0;
      if (issue) begin
         setMask[dest] = 1'b1;
         if (src1Valid) setMask[src1] = 1'b1;
         if (src2Valid) setMask[src2] = 1'b1;
         if (destSpecialValid) setMask[destSpecial] = 1'b1;
      end
   end

   always_comb begin
      clrMask = '0;
      if (wbValid) begin
         clrMask[wbDest] = 1'b1;
         if (wbSrc1Valid) clrMask[wbSrc1] = 1'b1;
         if (wbSrc2Valid) clrMask[wbSrc2] = 1'b1;
         if (wbDestSpecialValid) clrMask[wbDestSpecial] = 1'b1;
      end
   end

   always_ff @(posedge bus or negedge arstN) begin
      if (!arstN) begin
         inUse <= '0;
      end else begin
         inUse <= (inUse & ~clrMask) | setMask; // masks never overlap when stall is obeyed
      end
   end

   // the decoder holds its bytes while a hazard is reported
   issueDuringStall: assert property (
      @(posedge bus) disable iff (!arstN)
      issue |-> !stall
   );

   // execute retires only what was issued earlier
   retireUnmarked: assert property (
      @(posedge bus) disable iff (!arstN)
      wbValid |-> ((clrMask & ~inUse) == '0)
   );

endmodule

`default_nettype wire
